// ==== hw/rvDecodePkg.sv ====
// shared widths, register identifiers and micro-op encodings for the jumbo96 decoder
// imported by every RTL stage and by the testbench reference model
package rvDecodePkg;

	typedef logic [31:0] instrWord_t;
	// bit 24 jumbo, bit 25 jumbo96, bit 26 Au
	typedef logic [27:0] jumboBits_t;
	typedef logic [6:0]  regId_t;
	typedef logic [32:0] immVal_t;
	// {condition, command}
	typedef logic [8:0]  uCmd_t;
	// {class, index}
	typedef logic [8:0]  uIxt_t;
	typedef logic [3:0]  ldOp_t;

	// internal register selectors, 0..63 are general registers
	localparam regId_t GR_SP  = 7'h0F;
	localparam regId_t GR_ZZR = 7'h40;
	localparam regId_t GR_IMM = 7'h41;
	localparam regId_t GR_BPC = 7'h42;
	localparam regId_t GR_LR  = 7'h43;
	localparam regId_t GR_GBR = 7'h44;

	// major opcodes, instr[6:2]
	localparam logic [4:0] OPC_OPIMM = 5'b00100;
	localparam logic [4:0] OPC_AUIPC = 5'b00101;
	localparam logic [4:0] OPC_OP32  = 5'b00110;
	localparam logic [4:0] OPC_AMO   = 5'b01011;
	localparam logic [4:0] OPC_LUI   = 5'b01101;
	localparam logic [4:0] OPC_JALR  = 5'b11001;
	localparam logic [4:0] OPC_JAL   = 5'b11011;

	typedef enum logic [5:0] {
		UCMD_INVOP   = 6'h00,
		UCMD_JSR     = 6'h01,
		UCMD_JMP     = 6'h02,
		UCMD_MOV_RM  = 6'h03,
		UCMD_MOV_MR  = 6'h04,
		UCMD_ALU3    = 6'h05,
		UCMD_SHADQ3  = 6'h06,
		UCMD_SHAD3   = 6'h07,
		UCMD_QMULDIV = 6'h08,
		UCMD_LEA_MR  = 6'h09,
		UCMD_MOV_IR  = 6'h0A
	} nmid_e;

	typedef enum logic [2:0] {
		FMID_Z         = 3'd0,
		FMID_INV       = 3'd1,
		FMID_REGIMMREG = 3'd2,
		FMID_IMM8REG   = 3'd3,
		FMID_PCDISP8   = 3'd4
	} fmid_e;

	typedef enum logic [3:0] {
		ITY_SB = 4'd0,
		ITY_SW = 4'd1,
		ITY_NB = 4'd2
	} ity_e;

	// branch types used by the PC-relative forms
	localparam logic [2:0] BTY_SB = 3'd0;
	localparam logic [2:0] BTY_SW = 3'd1;

	localparam logic [2:0] CC_AL   = 3'd0;
	localparam logic [2:0] UCTY_SC = 3'd0;

	// command indexes
	localparam logic [5:0] UCIX_ALU_ADD     = 6'h00;
	localparam logic [5:0] UCIX_ALU_ADDSL   = 6'h01;
	localparam logic [5:0] UCIX_ALU_SLTSQ   = 6'h02;
	localparam logic [5:0] UCIX_ALU_SLTUQ   = 6'h03;
	localparam logic [5:0] UCIX_ALU_SLTSL   = 6'h04;
	localparam logic [5:0] UCIX_ALU_SLTUL   = 6'h05;
	localparam logic [5:0] UCIX_ALU_XOR     = 6'h06;
	localparam logic [5:0] UCIX_ALU_OR      = 6'h07;
	localparam logic [5:0] UCIX_ALU_AND     = 6'h08;
	localparam logic [5:0] UCIX_SHAD_SHLD3  = 6'h10;
	localparam logic [5:0] UCIX_SHAD_SHLR3  = 6'h11;
	localparam logic [5:0] UCIX_SHAD_SHAR3  = 6'h12;
	localparam logic [5:0] UCIX_SHAD_SHLDQ3 = 6'h13;
	localparam logic [5:0] UCIX_SHAD_SHLRQ3 = 6'h14;
	localparam logic [5:0] UCIX_SHAD_SHARQ3 = 6'h15;
	localparam logic [5:0] UCIX_QMUL_MULSL  = 6'h20;
	localparam logic [5:0] UCIX_QMUL_MULHSL = 6'h21;
	localparam logic [5:0] UCIX_QMUL_MULUL  = 6'h22;
	localparam logic [5:0] UCIX_QMUL_MULHUL = 6'h23;
	localparam logic [5:0] UCIX_QMUL_DIVSL  = 6'h24;
	localparam logic [5:0] UCIX_QMUL_DIVUL  = 6'h25;
	localparam logic [5:0] UCIX_QMUL_MODSL  = 6'h26;
	localparam logic [5:0] UCIX_QMUL_MODUL  = 6'h27;
	localparam logic [5:0] UCIX_LDI_LDIX    = 6'h30;

endpackage

// ==== hw/decodeIfs.sv ====
// bundles passed between the decode stages
// operandIf carries mapped registers and immediates, classIf the opcode class
`timescale 1ns/1ns

interface operandIf;
	import rvDecodePkg::*;

	regId_t  regN;
	regId_t  regM;
	regId_t  regO;
	immVal_t imm12s;
	immVal_t imm12n;
	immVal_t imm16s;
	immVal_t disp20s;

	modport source (output regN, regM, regO, imm12s, imm12n, imm16s, disp20s);
	modport sink   (input  regN, regM, regO, imm12s, imm12n, imm16s, disp20s);
endinterface

interface classIf;
	import rvDecodePkg::*;

	nmid_e      nmid;
	fmid_e      fmid;
	ity_e       ity;
	logic [2:0] bty;
	logic [5:0] uCmdIx;
	ldOp_t      amoLdOp;

	modport source (output nmid, fmid, ity, bty, uCmdIx, amoLdOp);
	modport sink   (input  nmid, fmid, ity, bty, uCmdIx, amoLdOp);
endinterface

// ==== hw/rvOperandExtract.sv ====
// register field mapping and immediate construction for one base instruction
// the jumbo prefix widens immediates and the Au prefix extends the register bank
`timescale 1ns/1ns

module rvOperandExtract (
	input  rvDecodePkg::instrWord_t instr,
	input  rvDecodePkg::jumboBits_t jumbo,
	operandIf.source                ops
);
	import rvDecodePkg::*;

	logic    isJumbo;
	logic    isJumboAu;
	logic    extN;
	logic    extM;
	logic    extO;
	immVal_t imm12u;
	immVal_t imm12s;
	immVal_t imm16s;

	// low 4 bits of a RISC-V register number to the internal register
	function automatic regId_t mapLow(input logic [3:0] idx);
		regId_t r;
		case (idx)
			4'h0: r = GR_ZZR;
			4'h1: r = GR_LR;
			4'h2: r = GR_SP;
			4'h3: r = GR_GBR;
			4'hE: r = 7'd2;
			4'hF: r = 7'd3;
			default: r = {3'b000, idx};
		endcase
		return r;
	endfunction

	// an extension bit or the upper half of the field bypasses the table
	function automatic regId_t mapField(input logic [4:0] field, input logic ext);
		regId_t r;
		if (!field[4] && !ext)
			r = mapLow(field[3:0]);
		else
			r = {1'b0, ext, field};
		return r;
	endfunction

	assign isJumbo   = jumbo[24];
	assign isJumboAu = jumbo[24] && jumbo[26];

	// Au gives bit 5 of N, M and O
	assign extN = isJumboAu && jumbo[18];
	assign extM = isJumboAu && jumbo[19];
	assign extO = isJumboAu && jumbo[20];

	assign ops.regN = mapField(instr[11:7], extN);
	assign ops.regM = mapField(instr[19:15], extM);
	assign ops.regO = mapField(instr[24:20], extO);

	assign imm12u     = {21'h000000, instr[31:20]};
	assign ops.imm12n = {21'h1FFFFF, instr[31:20]};

	always_comb begin
		imm12s = instr[31] ? ops.imm12n : imm12u;
		if (isJumboAu)
			imm12s[21:11] = jumbo[10:0];
		else if (isJumbo)
			imm12s[31:11] = jumbo[20:0];
	end

	always_comb begin
		imm16s = {instr[31], instr[31:12], 12'h000};
		// low bits of the upper immediate come from the prefix
		if (isJumbo)
			imm16s[11:0] = {jumbo[23], jumbo[10:0]};
	end

	assign ops.imm12s = imm12s;
	assign ops.imm16s = imm16s;

	// JAL offset with the implied zero dropped
	assign ops.disp20s = isJumbo ? imm16s :
		{{14{instr[31]}}, instr[19:12], instr[20], instr[30:21]};

endmodule

// ==== hw/rvOpClassifier.sv ====
// opcode and funct decode into command, form, immediate type and AMO load-op
// non-RV, compressed or non-jumbo96 words collapse to the no-operand form
`timescale 1ns/1ns

module rvOpClassifier (
	input  rvDecodePkg::instrWord_t instr,
	input  rvDecodePkg::jumboBits_t jumbo,
	input  logic                    rvMode,
	classIf.source                  cls
);
	import rvDecodePkg::*;

	logic isNotFx;
	logic rdIsZero;

	assign isNotFx  = !rvMode || (instr[1:0] != 2'b11);
	assign rdIsZero = (instr[11:7] == 5'h00);

	always_comb begin
		cls.nmid    = UCMD_INVOP;
		cls.fmid    = FMID_INV;
		cls.ity     = ITY_SB;
		cls.bty     = 3'd0;
		cls.uCmdIx  = 6'h00;
		cls.amoLdOp = 4'd0;

		case (instr[6:2])
			OPC_JALR: begin
				cls.nmid = rdIsZero ? UCMD_JMP : UCMD_JSR;
				cls.fmid = FMID_REGIMMREG;
				cls.ity  = ITY_SW;
			end
			OPC_JAL: begin
				cls.nmid = rdIsZero ? UCMD_JMP : UCMD_JSR;
				cls.fmid = FMID_PCDISP8;
				cls.ity  = ITY_SW;
				cls.bty  = BTY_SW;
			end
			OPC_AUIPC: begin
				cls.nmid = UCMD_LEA_MR;
				cls.fmid = FMID_PCDISP8;
				cls.ity  = ITY_SB;
				cls.bty  = BTY_SB;
			end
			OPC_LUI: begin
				cls.nmid   = UCMD_MOV_IR;
				cls.fmid   = FMID_IMM8REG;
				cls.ity    = ITY_SB;
				cls.uCmdIx = UCIX_LDI_LDIX;
			end
			OPC_OPIMM: begin
				cls.nmid = UCMD_ALU3;
				cls.fmid = FMID_REGIMMREG;
				cls.ity  = ITY_SW;
				case (instr[14:12])
					3'b000: cls.uCmdIx = UCIX_ALU_ADD;
					3'b001: begin
						cls.nmid   = UCMD_SHADQ3;
						cls.uCmdIx = UCIX_SHAD_SHLDQ3;
					end
					3'b010: cls.uCmdIx = UCIX_ALU_SLTSQ;
					3'b011: cls.uCmdIx = UCIX_ALU_SLTUQ;
					3'b100: cls.uCmdIx = UCIX_ALU_XOR;
					3'b101: begin
						cls.nmid   = UCMD_SHADQ3;
						cls.uCmdIx = instr[30] ? UCIX_SHAD_SHARQ3 : UCIX_SHAD_SHLRQ3;
					end
					3'b110: cls.uCmdIx = UCIX_ALU_OR;
					default: cls.uCmdIx = UCIX_ALU_AND;
				endcase
			end
			OPC_OP32: begin
				cls.fmid = FMID_REGIMMREG;
				cls.ity  = ITY_SW;
				// funct7 of 0000001 selects the multiply/divide unit
				if (instr[30:25] == 6'h01) begin
					cls.nmid = UCMD_QMULDIV;
					case (instr[14:12])
						3'b000: cls.uCmdIx = UCIX_QMUL_MULSL;
						3'b001: cls.uCmdIx = UCIX_QMUL_MULHSL;
						3'b010: cls.uCmdIx = UCIX_QMUL_MULUL;
						3'b011: cls.uCmdIx = UCIX_QMUL_MULHUL;
						3'b100: cls.uCmdIx = UCIX_QMUL_DIVSL;
						3'b101: cls.uCmdIx = UCIX_QMUL_DIVUL;
						3'b110: cls.uCmdIx = UCIX_QMUL_MODSL;
						default: cls.uCmdIx = UCIX_QMUL_MODUL;
					endcase
				end else begin
					cls.nmid = UCMD_ALU3;
					case (instr[14:12])
						3'b000: cls.uCmdIx = UCIX_ALU_ADDSL;
						3'b001: begin
							cls.nmid   = UCMD_SHAD3;
							cls.uCmdIx = UCIX_SHAD_SHLD3;
						end
						3'b010: cls.uCmdIx = UCIX_ALU_SLTSL;
						3'b011: cls.uCmdIx = UCIX_ALU_SLTUL;
						3'b100: cls.uCmdIx = UCIX_ALU_XOR;
						3'b101: begin
							cls.nmid   = UCMD_SHAD3;
							cls.uCmdIx = instr[30] ? UCIX_SHAD_SHAR3 : UCIX_SHAD_SHLR3;
						end
						3'b110: cls.uCmdIx = UCIX_ALU_OR;
						default: cls.uCmdIx = UCIX_ALU_AND;
					endcase
				end
			end
			OPC_AMO: begin
				cls.nmid   = UCMD_MOV_RM;
				cls.fmid   = FMID_REGIMMREG;
				cls.ity    = ITY_NB;
				cls.bty    = instr[14:12];
				cls.uCmdIx = {instr[13:12], 1'b0, instr[14], 2'b00};
				// funct5 picks the read-modify-write operation
				case (instr[31:27])
					5'b00000: cls.amoLdOp = 4'd2;
					5'b00001: cls.amoLdOp = 4'd1;
					5'b00010: cls.nmid    = UCMD_MOV_MR;
					5'b00100: cls.amoLdOp = 4'd7;
					5'b01100: cls.amoLdOp = 4'd5;
					5'b01000: cls.amoLdOp = 4'd6;
					default:  cls.amoLdOp = 4'd0;
				endcase
				if (instr[26])
					cls.amoLdOp[3] = 1'b1;
			end
			default: begin
			end
		endcase

		if (isNotFx || !jumbo[25]) begin
			cls.fmid = FMID_Z;
			cls.ity  = ITY_SB;
		end
	end

endmodule

// ==== hw/rvFormRouter.sv ====
// picks register selectors, immediate and command words for the decoded form
// purely combinational, feeds the result registers of the top level
`timescale 1ns/1ns

module rvFormRouter (
	operandIf.sink              ops,
	classIf.sink                cls,
	output rvDecodePkg::regId_t regN,
	output rvDecodePkg::regId_t regM,
	output rvDecodePkg::regId_t regO,
	output rvDecodePkg::regId_t regP,
	output rvDecodePkg::immVal_t imm,
	output rvDecodePkg::uCmd_t  uCmd,
	output rvDecodePkg::uIxt_t  uIxt,
	output rvDecodePkg::ldOp_t  ldOp
);
	import rvDecodePkg::*;

	always_comb begin
		regN = GR_ZZR;
		regM = GR_ZZR;
		regO = GR_ZZR;
		regP = GR_ZZR;
		imm  = '0;
		uCmd = {CC_AL, cls.nmid};
		uIxt = {UCTY_SC, cls.uCmdIx};
		ldOp = 4'd0;

		case (cls.fmid)
			FMID_INV: begin
				uCmd = {CC_AL, UCMD_INVOP};
			end
			FMID_REGIMMREG: begin
				regN = ops.regN;
				regP = ops.regN;
				regM = ops.regM;
				regO = GR_IMM;
				case (cls.ity)
					ITY_SW: imm = ops.imm12s;
					// AMO: address in M, store data in P
					ITY_NB: begin
						regO = GR_ZZR;
						regP = ops.regO;
						ldOp = cls.amoLdOp;
					end
					default: begin
					end
				endcase
			end
			FMID_IMM8REG: begin
				regN = ops.regN;
				regM = ops.regN;
				regP = ops.regN;
				regO = GR_IMM;
				imm  = ops.imm16s;
			end
			FMID_PCDISP8: begin
				regN = ops.regN;
				regP = ops.regN;
				regM = GR_BPC;
				regO = GR_IMM;
				uIxt = {UCTY_SC, cls.bty[1:0], 1'b0, cls.bty};
				if (cls.ity == ITY_SW)
					imm = ops.disp20s;
				else
					imm = ops.imm16s;
			end
			default: begin
				// form Z leaves every selector at ZZR
			end
		endcase
	end

endmodule

// ==== hw/rvJumboDecoder.sv ====
// jumbo96 RISC-V decoder with a four-phase req/ack handshake
// one request in flight, ack rises with the registered micro-op and holds until req falls
`timescale 1ns/1ns

module rvJumboDecoder (
	input  logic                    clock,
	input  logic                    rst,
	input  logic                    req,
	input  logic                    rvMode,
	input  rvDecodePkg::instrWord_t instr,
	input  rvDecodePkg::jumboBits_t jumbo,
	output logic                    ack,
	output rvDecodePkg::regId_t     regN,
	output rvDecodePkg::regId_t     regM,
	output rvDecodePkg::regId_t     regO,
	output rvDecodePkg::regId_t     regP,
	output rvDecodePkg::immVal_t    imm,
	output rvDecodePkg::uCmd_t      uCmd,
	output rvDecodePkg::uIxt_t      uIxt,
	output rvDecodePkg::ldOp_t      ldOp
);
	import rvDecodePkg::*;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_DECODE,
		ST_HOLD
	} state_e;

	state_e     state;
	instrWord_t instrQ;
	jumboBits_t jumboQ;
	logic       rvModeQ;
	regId_t     nextN;
	regId_t     nextM;
	regId_t     nextO;
	regId_t     nextP;
	immVal_t    nextImm;
	uCmd_t      nextCmd;
	uIxt_t      nextIxt;
	ldOp_t      nextLdOp;

	operandIf opsBus ();
	classIf   clsBus ();

	rvOperandExtract i_rvOperandExtract (
		.instr (instrQ),
		.jumbo (jumboQ),
		.ops   (opsBus)
	);

	rvOpClassifier i_rvOpClassifier (
		.instr  (instrQ),
		.jumbo  (jumboQ),
		.rvMode (rvModeQ),
		.cls    (clsBus)
	);

	rvFormRouter i_rvFormRouter (
		.ops  (opsBus),
		.cls  (clsBus),
		.regN (nextN),
		.regM (nextM),
		.regO (nextO),
		.regP (nextP),
		.imm  (nextImm),
		.uCmd (nextCmd),
		.uIxt (nextIxt),
		.ldOp (nextLdOp)
	);

	// capture once per request
	always_ff @(posedge clock) begin
		if (state == ST_IDLE && req) begin
			instrQ  <= instr;
			jumboQ  <= jumbo;
			rvModeQ <= rvMode;
		end
	end

	always_ff @(posedge clock) begin
		if (rst) begin
			state <= ST_IDLE;
		end else begin
			case (state)
				ST_IDLE:   if (req) state <= ST_DECODE;
				ST_DECODE: state <= ST_HOLD;
				// wait for the requester to drop req
				ST_HOLD:   if (!req) state <= ST_IDLE;
				default:   state <= ST_IDLE;
			endcase
		end
	end

	// results load together with the rise of ack
	always_ff @(posedge clock) begin
		if (rst) begin
			regN <= '0;
			regM <= '0;
			regO <= '0;
			regP <= '0;
			imm  <= '0;
			uCmd <= '0;
			uIxt <= '0;
			ldOp <= '0;
		end else if (state == ST_DECODE) begin
			regN <= nextN;
			regM <= nextM;
			regO <= nextO;
			regP <= nextP;
			imm  <= nextImm;
			uCmd <= nextCmd;
			uIxt <= nextIxt;
			ldOp <= nextLdOp;
		end
	end

	assign ack = (state == ST_HOLD);

endmodule

// ==== bench/rvJumboDecoder_chk.sv ====
// four-phase handshake assertions for the jumbo96 decoder
// bound into the top level, failures are counted for the closing summary
`timescale 1ns/1ns

module rvJumboDecoder_chk (
	input logic                  clock,
	input logic                  rst,
	input logic                  req,
	input logic                  ack,
	input rvDecodePkg::regId_t   regN,
	input rvDecodePkg::regId_t   regM,
	input rvDecodePkg::regId_t   regO,
	input rvDecodePkg::regId_t   regP,
	input rvDecodePkg::immVal_t  imm,
	input rvDecodePkg::uCmd_t    uCmd,
	input rvDecodePkg::uIxt_t    uIxt,
	input rvDecodePkg::ldOp_t    ldOp
);
	logic [82:0] result;
	int          failCount = 0;

	assign result = {regN, regM, regO, regP, imm, uCmd, uIxt, ldOp};

	// reset clears ack and every result register
	ackLowAfterReset: assert property (@(posedge clock) rst |=> !ack && result == '0)
		else begin
			$error("ack or outputs not cleared by reset");
			failCount++;
		end

	// capture edge, then one decode cycle with ack still low
	noEarlyAck: assert property (@(posedge clock) disable iff (rst) $rose(req) |=> !ack)
		else begin
			$error("ack rose during the decode cycle");
			failCount++;
		end

	ackLatency: assert property (@(posedge clock) disable iff (rst) $rose(req) |-> ##2 ack)
		else begin
			$error("ack not high two cycles after capture");
			failCount++;
		end

	ackFall: assert property (@(posedge clock) disable iff (rst) ack && !req |=> !ack)
		else begin
			$error("ack did not fall one cycle after req dropped");
			failCount++;
		end

	holdWhileAck: assert property (@(posedge clock) disable iff (rst)
		ack |=> !ack || $stable(result))
		else begin
			$error("outputs changed while ack was high");
			failCount++;
		end

endmodule

// ==== bench/rvJumboDecoderTb.sv ====
// testbench for the jumbo96 decoder with four-phase requests of directed and random words
// every micro-op is compared against a reference model built from the decode rules
`timescale 1ns/1ns

module rvJumboDecoderTb;
	import rvDecodePkg::*;

	logic       clock;
	logic       rst;
	logic       req;
	logic       rvMode;
	instrWord_t instr;
	jumboBits_t jumbo;
	logic       ack;
	regId_t     regN;
	regId_t     regM;
	regId_t     regO;
	regId_t     regP;
	immVal_t    imm;
	uCmd_t      uCmd;
	uIxt_t      uIxt;
	ldOp_t      ldOp;

	// expected micro-op
	regId_t  expN;
	regId_t  expM;
	regId_t  expO;
	regId_t  expP;
	immVal_t expImm;
	uCmd_t   expCmd;
	uIxt_t   expIxt;
	ldOp_t   expLdOp;

	int mismatches = 0;
	int timeouts = 0;
	int checks = 0;

	// funct5 values of the AMO table plus one outside it
	logic [4:0] amoF5 [7] = '{5'd0, 5'd1, 5'd2, 5'd4, 5'd12, 5'd8, 5'd20};

	rvJumboDecoder i_rvJumboDecoder (.*);

	bind rvJumboDecoder rvJumboDecoder_chk i_rvJumboDecoderChk (.*);

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	function automatic regId_t expReg(input logic [4:0] f, input logic ext);
		if (ext || f[4])
			return {1'b0, ext, f};
		case (f[3:0])
			4'd0: return GR_ZZR;
			4'd1: return GR_LR;
			4'd2: return GR_SP;
			4'd3: return GR_GBR;
			4'd14: return 7'd2;
			4'd15: return 7'd3;
			default: return {2'b00, f};
		endcase
	endfunction

	function automatic logic [5:0] aluIndex(input logic [2:0] f3, input logic arith,
			input logic word);
		case (f3)
			3'd0: return word ? UCIX_ALU_ADDSL : UCIX_ALU_ADD;
			3'd1: return word ? UCIX_SHAD_SHLD3 : UCIX_SHAD_SHLDQ3;
			3'd2: return word ? UCIX_ALU_SLTSL : UCIX_ALU_SLTSQ;
			3'd3: return word ? UCIX_ALU_SLTUL : UCIX_ALU_SLTUQ;
			3'd4: return UCIX_ALU_XOR;
			3'd5: begin
				if (word)
					return arith ? UCIX_SHAD_SHAR3 : UCIX_SHAD_SHLR3;
				return arith ? UCIX_SHAD_SHARQ3 : UCIX_SHAD_SHLRQ3;
			end
			3'd6: return UCIX_ALU_OR;
			default: return UCIX_ALU_AND;
		endcase
	endfunction

	// AMO access width selects the index row
	function automatic logic [5:0] amoIndex(input logic [2:0] f3);
		case (f3)
			3'b000: return 6'h00;
			3'b001: return 6'h10;
			3'b010: return 6'h20;
			3'b011: return 6'h30;
			3'b100: return 6'h04;
			3'b101: return 6'h14;
			3'b110: return 6'h24;
			default: return 6'h34;
		endcase
	endfunction

	function automatic ldOp_t amoLoadOp(input logic [4:0] f5);
		case (f5)
			5'b00000: return 4'd2;
			5'b00001: return 4'd1;
			5'b00100: return 4'd7;
			5'b01100: return 4'd5;
			5'b01000: return 4'd6;
			default: return 4'd0;
		endcase
	endfunction

	task automatic route(input regId_t n, input regId_t m, input regId_t o, input regId_t p,
			input immVal_t v);
		expN = n;
		expM = m;
		expO = o;
		expP = p;
		expImm = v;
	endtask

	task automatic predict(input instrWord_t i, input jumboBits_t j, input logic mode);
		logic       au;
		logic       isJ;
		logic       word;
		regId_t     rN;
		regId_t     rM;
		regId_t     rO;
		immVal_t    i12;
		immVal_t    i16;
		immVal_t    d20;
		logic [5:0] cmd;
		logic [5:0] ix;
		isJ = j[24];
		au = j[24] & j[26];
		word = (i[6:2] == OPC_OP32);
		rN = expReg(i[11:7], au & j[18]);
		rM = expReg(i[19:15], au & j[19]);
		rO = expReg(i[24:20], au & j[20]);
		i12 = {{21{i[31]}}, i[31:20]};
		if (au)
			i12[21:11] = j[10:0];
		else if (isJ)
			i12[31:11] = j[20:0];
		i16 = {i[31], i[31:12], isJ ? {j[23], j[10:0]} : 12'h000};
		d20 = isJ ? i16 : {{13{i[31]}}, i[31], i[19:12], i[20], i[30:21]};
		cmd = UCMD_INVOP;
		ix = 6'h00;
		expLdOp = 4'd0;
		route(GR_ZZR, GR_ZZR, GR_ZZR, GR_ZZR, '0);
		case (i[6:2])
			OPC_JALR, OPC_JAL: begin
				cmd = (i[11:7] == 5'd0) ? UCMD_JMP : UCMD_JSR;
				if (i[6:2] == OPC_JAL) begin
					// SW branch type lands in the index
					ix = 6'b01_0_001;
					route(rN, GR_BPC, GR_IMM, rN, d20);
				end else begin
					route(rN, rM, GR_IMM, rN, i12);
				end
			end
			OPC_AUIPC: begin
				cmd = UCMD_LEA_MR;
				route(rN, GR_BPC, GR_IMM, rN, i16);
			end
			OPC_LUI: begin
				cmd = UCMD_MOV_IR;
				ix = UCIX_LDI_LDIX;
				route(rN, rN, GR_IMM, rN, i16);
			end
			OPC_OPIMM, OPC_OP32: begin
				if (word && i[30:25] == 6'h01) begin
					cmd = UCMD_QMULDIV;
					ix = UCIX_QMUL_MULSL | {3'b000, i[14:12]};
				end else begin
					cmd = (i[13:12] == 2'b01) ? (word ? UCMD_SHAD3 : UCMD_SHADQ3) : UCMD_ALU3;
					ix = aluIndex(i[14:12], i[30], word);
				end
				route(rN, rM, GR_IMM, rN, i12);
			end
			OPC_AMO: begin
				cmd = (i[31:27] == 5'b00010) ? UCMD_MOV_MR : UCMD_MOV_RM;
				ix = amoIndex(i[14:12]);
				route(rN, rM, GR_ZZR, rO, '0);
				expLdOp = amoLoadOp(i[31:27]) | {i[26], 3'b000};
			end
			default: begin
			end
		endcase
		// no-operand form
		if (!mode || i[1:0] != 2'b11 || !j[25]) begin
			route(GR_ZZR, GR_ZZR, GR_ZZR, GR_ZZR, '0);
			expLdOp = 4'd0;
			// the branch type reaches the index only in the PC-relative form
			if (i[6:2] == OPC_JAL)
				ix = 6'h00;
		end
		expCmd = {CC_AL, cmd};
		expIxt = {UCTY_SC, ix};
	endtask

	task automatic checkField(input string name, input logic [32:0] got, input logic [32:0] exp);
		assert (got === exp)
		else begin
			$display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
			mismatches++;
		end
	endtask

	task automatic runOne(input instrWord_t i, input jumboBits_t j, input logic mode);
		int n;
		@(negedge clock);
		instr = i;
		jumbo = j;
		rvMode = mode;
		req = 1'b1;
		n = 0;
		while (ack !== 1'b1 && n < 100) begin
			@(negedge clock);
			n++;
		end
		if (ack !== 1'b1) begin
			$display("timeout at %0t: ack did not rise for instr %h", $time, i);
			timeouts++;
		end else begin
			predict(i, j, mode);
			checks++;
			checkField("regN", 33'(regN), 33'(expN));
			checkField("regM", 33'(regM), 33'(expM));
			checkField("regO", 33'(regO), 33'(expO));
			checkField("regP", 33'(regP), 33'(expP));
			checkField("imm", imm, expImm);
			checkField("uCmd", 33'(uCmd), 33'(expCmd));
			checkField("uIxt", 33'(uIxt), 33'(expIxt));
			checkField("ldOp", 33'(ldOp), 33'(expLdOp));
		end
		// requester back-pressure
		repeat ($urandom_range(0, 3)) @(negedge clock);
		req = 1'b0;
		n = 0;
		while (ack !== 1'b0 && n < 100) begin
			@(negedge clock);
			n++;
		end
		if (ack !== 1'b0) begin
			$display("timeout at %0t: ack did not fall after req dropped", $time);
			timeouts++;
		end
	endtask

	function automatic instrWord_t randInstr();
		instrWord_t w;
		w = $urandom;
		w[1:0] = 2'b11;
		case ($urandom_range(0, 7))
			0: w[6:2] = OPC_JAL;
			1: w[6:2] = OPC_JALR;
			2: w[6:2] = OPC_AUIPC;
			3: w[6:2] = OPC_LUI;
			4: w[6:2] = OPC_OPIMM;
			5: begin
				w[6:2] = OPC_OP32;
				w[31:25] = $urandom_range(0, 1) ? 7'h01 : {1'b0, w[30], 5'h00};
			end
			6: begin
				w[6:2] = OPC_AMO;
				w[31:27] = amoF5[3'($urandom_range(0, 6))];
			end
			default: w[6:2] = 5'($urandom);
		endcase
		if ($urandom_range(0, 7) == 0)
			w[11:7] = 5'd0;
		return w;
	endfunction

	initial begin
		instrWord_t w;
		jumboBits_t j;
		logic       m;
		rst = 1'b1;
		req = 1'b0;
		rvMode = 1'b0;
		instr = '0;
		jumbo = '0;
		void'($urandom(32'hfa5e_4565));
		repeat (16) @(negedge clock);
		rst = 1'b0;

		// jal x0 and jalr x0 give JMP
		runOne(32'h0000_006f, 28'h200_0000, 1'b1);
		runOne(32'h0000_8067, 28'h200_0000, 1'b1);
		// lui with the full jumbo and Au prefix
		runOne(32'h1234_50b7, 28'h7ff_ffff, 1'b1);
		// nop without jumbo96, then an unknown opcode
		runOne(32'h0000_0013, 28'h000_0000, 1'b1);
		runOne(32'h0000_007f, 28'h200_0000, 1'b1);
		// amoswap with aq set, rvMode low
		runOne(32'h0c20_a1af, 28'h200_0000, 1'b0);

		repeat (400) begin
			w = randInstr();
			j = jumboBits_t'($urandom);
			j[25] = ($urandom_range(0, 7) != 0);
			m = ($urandom_range(0, 15) != 0);
			if ($urandom_range(0, 15) == 0)
				w[1:0] = 2'($urandom);
			runOne(w, j, m);
		end

		repeat (4) @(negedge clock);
		$display("checks %0d, mismatches %0d, timeouts %0d, protocol failures %0d",
			checks, mismatches, timeouts, i_rvJumboDecoder.i_rvJumboDecoderChk.failCount);
		if (mismatches == 0 && timeouts == 0 &&
				i_rvJumboDecoder.i_rvJumboDecoderChk.failCount == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

// ==== compile.f ====
hw/rvDecodePkg.sv
hw/decodeIfs.sv
hw/rvOperandExtract.sv
hw/rvOpClassifier.sv
hw/rvFormRouter.sv
hw/rvJumboDecoder.sv
bench/rvJumboDecoder_chk.sv
bench/rvJumboDecoderTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build the decoder testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" &&
	verilator --binary --timing --assert --top-module rvJumboDecoderTb -f compile.f &&
	./obj_dir/VrvJumboDecoderTb +verilator+error+limit+1000 | tee /dev/stderr |
	grep -q "^test passed$" || exit 1
